// File: source/spi_link_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi framing constants
// command byte kinds and the two-view command word
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package spi_link_pkg;

	localparam int byte_w = 8;                  // bits per spi byte

	// top two bits of every command byte
	typedef enum logic [1:0] {
		cmd_read  = 2'b00,                      // data bytes read back
		cmd_write = 2'b01,                      // data bytes written
		cmd_rsvd  = 2'b10,                      // ignored frame
		cmd_sys   = 2'b11                       // low bits are an opcode
	} cmd_kind_e;

	// same byte, decoded by kind
	typedef union packed {
		struct packed {
			cmd_kind_e   kind;
			logic [5:0]  addr;                  // start register
		} reg_cmd;
		struct packed {
			cmd_kind_e   kind;
			logic [5:0]  opcode;                // system operation
		} sys_cmd;
	} cmd_word_u;

endpackage

`default_nettype wire

// File: source/reg_map_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register bank map
// addresses, identity value, system opcodes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package reg_map_pkg;

	localparam int addr_w    = 3;               // upper command addr bits wrap
	localparam int reg_count = 8;

	// register addresses
	localparam logic [addr_w-1:0] reg_out_a     = 3'd0;  // drives out_port
	localparam logic [addr_w-1:0] reg_gp_lo     = 3'd1;  // first general reg
	localparam logic [addr_w-1:0] reg_gp_hi     = 3'd4;  // last general reg
	localparam logic [addr_w-1:0] reg_in_port   = 3'd5;  // read only
	localparam logic [addr_w-1:0] reg_frame_cnt = 3'd6;  // read only
	localparam logic [addr_w-1:0] reg_id        = 3'd7;  // read only

	localparam logic [7:0] id_value = 8'hA5;

	// returned on miso while the command byte shifts in
	localparam logic [7:0] status_byte = id_value;

	// system opcodes
	localparam logic [5:0] sys_op_clr_cnt = 6'd1;   // zero the frame counter

endpackage

`default_nettype wire

// File: source/spi_slave.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi slave byte engine
// cs/sclk edge detect, mode 0..3 shifting
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_slave #(
	parameter bit cpol = 1'b1,                  // sclk idle level
	parameter bit cpha = 1'b1                   // sample on second edge
) (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        cs,                      // active low select
	input  wire        sclk,
	input  wire        mosi,
	output wire        miso,
	input  wire [7:0]  tx_data,                 // next byte to send
	output wire [7:0]  rx_data,
	output wire        rx_valid,                // one cycle per byte
	output wire        frame_start,
	output wire        frame_end
);

	localparam int last_edge = 2 * spi_link_pkg::byte_w - 1;

	localparam logic [2:0] s0_idle      = 3'd0,  // reload tx, clear edge count
	                       s1_wait_edge = 3'd1,
	                       s2_edge      = 3'd2,  // act on one sclk edge
	                       s3_last_half = 3'd3,
	                       s4_ack       = 3'd4,  // byte done
	                       s5_finish    = 3'd5;

	logic [2:0] state;
	logic [4:0] cnt_edge;                       // sclk edges in this byte
	logic [7:0] tx_shift;
	logic [7:0] rx_shift;

	logic cs_d1, cs_d2;
	logic sclk_d1, sclk_d2;
	logic sclk_rise, sclk_fall;
	logic sclk_fir, sclk_sec;                   // first / second edge of a bit

	// two flop edge detectors
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_d1   <= 1'b1;                    // deselected
			cs_d2   <= 1'b1;
			sclk_d1 <= cpol;
			sclk_d2 <= cpol;
		end else begin
			cs_d1   <= cs;
			cs_d2   <= cs_d1;
			sclk_d1 <= sclk;
			sclk_d2 <= sclk_d1;
		end
	end

	assign frame_start = cs_d2 & ~cs_d1;        // cs fell
	assign frame_end   = ~cs_d2 & cs_d1;        // cs rose
	assign sclk_rise   = ~sclk_d2 & sclk_d1;
	assign sclk_fall   = sclk_d2 & ~sclk_d1;
	assign sclk_fir    = cpol ? sclk_fall : sclk_rise;  // leaves idle level
	assign sclk_sec    = cpol ? sclk_rise : sclk_fall;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= s0_idle;
		end else if (cs_d1) begin
			state <= s0_idle;                   // hold while deselected
		end else begin
			case (state)
				s0_idle:      state <= s1_wait_edge;
				s1_wait_edge: begin
					// even count waits for first edge, odd for second
					if ((~cnt_edge[0] & sclk_fir) | (cnt_edge[0] & sclk_sec))
						state <= s2_edge;
				end
				s2_edge:      state <= (cnt_edge == 5'(last_edge)) ? s3_last_half
				                                                    : s1_wait_edge;
				s3_last_half: state <= s4_ack;
				s4_ack:       state <= s5_finish;
				s5_finish:    state <= s0_idle;
				default:      state <= s0_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt_edge <= 5'd0;
		else if (state == s0_idle)
			cnt_edge <= 5'd0;
		else if (state == s2_edge)
			cnt_edge <= cnt_edge + 5'd1;
	end

	// transmit side, msb first
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			tx_shift <= 8'hFF;                  // miso idles high
		else if (state == s0_idle && !cs_d1)
			tx_shift <= tx_data;
		else if (state == s2_edge && cnt_edge[0] != cpha && !(cpha && cnt_edge == 5'd0))
			tx_shift <= {tx_shift[6:0], 1'b1};  // launch edge, first one skipped in cpha 1
	end

	// receive side
	always_ff @(posedge sys_clk) begin
		if (state == s0_idle && !cs_d1)
			rx_shift <= 8'h00;
		else if (state == s2_edge && cnt_edge[0] == cpha)
			rx_shift <= {rx_shift[6:0], mosi};  // sampling edge
	end

	assign miso     = tx_shift[7];
	assign rx_data  = rx_shift;
	assign rx_valid = (state == s4_ack);        // 2 cycles after last sample

endmodule

`default_nettype wire

// File: source/spi_cmd_ctrl.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi frame controller
// command decode, address walk, strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_ctrl (
	input  wire                              sys_clk,
	input  wire                              sys_rst_n,
	input  wire [spi_link_pkg::byte_w-1:0]   rx_data,
	input  wire                              rx_valid,
	input  wire                              frame_start,
	input  wire                              frame_end,
	output logic [spi_link_pkg::byte_w-1:0]  tx_data,
	output logic [reg_map_pkg::addr_w-1:0]   reg_addr,
	output logic                             wr_en,
	output logic [spi_link_pkg::byte_w-1:0]  wr_data,
	input  wire [spi_link_pkg::byte_w-1:0]   rd_data,
	output logic                             clr_cnt,
	output logic                             frame_done
);

	spi_link_pkg::cmd_word_u  cmd_word;         // rx byte seen as a command
	spi_link_pkg::cmd_kind_e  kind_q;           // class of current frame
	logic                     in_cmd;           // next byte is the command
	logic                     got_byte;         // frame had a full byte
	logic                     rx_valid_q;

	assign cmd_word = rx_data;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			in_cmd   <= 1'b1;
			got_byte <= 1'b0;
			kind_q   <= spi_link_pkg::cmd_rsvd;  // nothing acted on
			reg_addr <= '0;
			wr_en    <= 1'b0;
			clr_cnt  <= 1'b0;
		end else begin
			wr_en   <= 1'b0;                    // strobes default low
			clr_cnt <= 1'b0;
			if (frame_start) begin
				in_cmd   <= 1'b1;
				got_byte <= 1'b0;
				kind_q   <= spi_link_pkg::cmd_rsvd;
			end else if (rx_valid) begin
				got_byte <= 1'b1;
				if (in_cmd) begin
					in_cmd <= 1'b0;
					kind_q <= cmd_word.reg_cmd.kind;
					if (cmd_word.reg_cmd.kind == spi_link_pkg::cmd_read ||
					    cmd_word.reg_cmd.kind == spi_link_pkg::cmd_write)
						reg_addr <= cmd_word.reg_cmd.addr[reg_map_pkg::addr_w-1:0];
					if (cmd_word.sys_cmd.kind == spi_link_pkg::cmd_sys &&
					    cmd_word.sys_cmd.opcode == reg_map_pkg::sys_op_clr_cnt)
						clr_cnt <= 1'b1;        // unknown opcodes fall through
				end else if (kind_q == spi_link_pkg::cmd_write) begin
					wr_en <= 1'b1;
				end else if (kind_q == spi_link_pkg::cmd_read) begin
					reg_addr <= reg_addr + 1'b1;  // wraps at addr_w bits
				end
			end else if (wr_en) begin
				reg_addr <= reg_addr + 1'b1;    // step after the write lands
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (rx_valid)
			wr_data <= rx_data;
	end

	// tx byte for the slave's next reload
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			rx_valid_q <= 1'b0;
			tx_data    <= reg_map_pkg::status_byte;
			frame_done <= 1'b0;
		end else begin
			rx_valid_q <= rx_valid;
			frame_done <= frame_end & got_byte;  // empty frames not counted
			if (frame_end)
				tx_data <= reg_map_pkg::status_byte;  // ready for next command
			else if (rx_valid_q)
				tx_data <= (kind_q == spi_link_pkg::cmd_read) ? rd_data
				                                              : reg_map_pkg::status_byte;
		end
	end

endmodule

`default_nettype wire

// File: source/spi_reg_file.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register bank
// rw regs, in_port sync, frame counter, id
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_reg_file (
	input  wire                             sys_clk,
	input  wire                             sys_rst_n,
	input  wire [reg_map_pkg::addr_w-1:0]   reg_addr,
	input  wire                             wr_en,
	input  wire [7:0]                       wr_data,
	output logic [7:0]                      rd_data,
	input  wire                             clr_cnt,
	input  wire                             frame_done,
	input  wire [7:0]                       in_port,
	output wire [7:0]                       out_port
);

	logic [7:0] rw_reg [reg_map_pkg::reg_out_a:reg_map_pkg::reg_gp_hi];
	logic [7:0] rd_vec [reg_map_pkg::reg_count];  // read view per address
	logic [7:0] in_meta, in_sync;
	logic [7:0] frame_cnt;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			for (int i = reg_map_pkg::reg_out_a; i <= reg_map_pkg::reg_gp_hi; i++)
				rw_reg[i] <= 8'h00;
		end else if (wr_en && reg_addr <= reg_map_pkg::reg_gp_hi) begin
			rw_reg[reg_addr] <= wr_data;        // read-only addresses dropped
		end
	end

	// in_port is asynchronous to sys_clk
	always_ff @(posedge sys_clk) begin
		in_meta <= in_port;
		in_sync <= in_meta;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			frame_cnt <= 8'h00;
		else if (clr_cnt)
			frame_cnt <= 8'h00;                 // clear wins
		else if (frame_done)
			frame_cnt <= frame_cnt + 8'h01;     // wraps at 255
	end

	always_comb begin
		for (int i = reg_map_pkg::reg_out_a; i <= reg_map_pkg::reg_gp_hi; i++)
			rd_vec[i] = rw_reg[i];
		rd_vec[reg_map_pkg::reg_in_port]   = in_sync;
		rd_vec[reg_map_pkg::reg_frame_cnt] = frame_cnt;
		rd_vec[reg_map_pkg::reg_id]        = reg_map_pkg::id_value;
	end

	assign rd_data  = rd_vec[reg_addr];
	assign out_port = rw_reg[reg_map_pkg::reg_out_a];

endmodule

`default_nettype wire

// File: source/spi_regbridge_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi register bridge top level
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_regbridge_top #(
	parameter bit cpol = 1'b1,
	parameter bit cpha = 1'b1
) (
	input  wire        sys_clk,
	input  wire        sys_rst_n,
	input  wire        cs,
	input  wire        sclk,
	input  wire        mosi,
	output wire        miso,
	input  wire [7:0]  in_port,
	output wire [7:0]  out_port
);

	wire [7:0] tx_data;                         // ctrl -> slave
	wire [7:0] rx_data;
	wire       rx_valid;
	wire       frame_start;
	wire       frame_end;
	wire [2:0] reg_addr;                        // ctrl -> bank
	wire       wr_en;
	wire [7:0] wr_data;
	wire [7:0] rd_data;
	wire       clr_cnt;
	wire       frame_done;

	spi_slave #(
		.cpol (cpol),
		.cpha (cpha)
	) spi_slave_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cs          (cs),
		.sclk        (sclk),
		.mosi        (mosi),
		.miso        (miso),
		.tx_data     (tx_data),
		.rx_data     (rx_data),
		.rx_valid    (rx_valid),
		.frame_start (frame_start),
		.frame_end   (frame_end)
	);

	spi_cmd_ctrl spi_cmd_ctrl_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.rx_data     (rx_data),
		.rx_valid    (rx_valid),
		.frame_start (frame_start),
		.frame_end   (frame_end),
		.tx_data     (tx_data),
		.reg_addr    (reg_addr),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.clr_cnt     (clr_cnt),
		.frame_done  (frame_done)
	);

	spi_reg_file spi_reg_file_inst (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.reg_addr    (reg_addr),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.rd_data     (rd_data),
		.clr_cnt     (clr_cnt),
		.frame_done  (frame_done),
		.in_port     (in_port),
		.out_port    (out_port)
	);

endmodule

`default_nettype wire

// File: test/spi_regbridge_assertions.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on the frame controller strobes
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_regbridge_assertions (
	input wire sys_clk,
	input wire sys_rst_n,
	input wire rx_valid,
	input wire wr_en,
	input wire clr_cnt
);

	wr_after_rx: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wr_en |-> $past(rx_valid))                    // write lands one cycle after a byte
		else $error("wr_en without rx_valid one cycle before");

	wr_clr_apart: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(wr_en && clr_cnt))
		else $error("wr_en and clr_cnt high in the same cycle");

	rx_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_valid |=> !rx_valid)                       // one pulse per byte
		else $error("rx_valid held for two cycles");

endmodule

`default_nettype wire

// File: test/tb_spi_regbridge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the spi register bridge
// mode 3 spi master, register model, random tests
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_spi_regbridge;

	localparam int half_period = 8;                    // sys_clk cycles per sclk half
	localparam int frame_gap   = 20;
	localparam int byte_cycles = 2 * half_period * spi_link_pkg::byte_w;
	// worst case of all tests, 287 frames carrying 378 bytes
	localparam int run_cycles  = 287 * (2 * half_period + frame_gap) + 378 * byte_cycles;
	localparam int timeout_cycles = run_cycles * 3 / 2 + 16;

	logic       sys_clk, sys_rst_n, cs, sclk, mosi;
	wire        miso;
	logic [7:0] in_port;
	wire  [7:0] out_port;

	logic [7:0] mosi_buf [0:15];                       // bytes of the current frame
	logic [7:0] miso_buf [0:15];
	logic [7:0] model_reg [0:7];                       // expected register contents
	logic [7:0] exp_cnt;
	logic [7:0] exp_id;
	int         seed;
	int         cycle_count;
	int         check_count;
	int         err_count;
	int         test_count;
	int         test_checks;                           // counts at test start
	int         test_errs;

	spi_regbridge_top #(
		.cpol (1'b1),
		.cpha (1'b1)
	) spi_regbridge_top_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.in_port   (in_port),
		.out_port  (out_port)
	);

	bind spi_cmd_ctrl spi_regbridge_assertions spi_regbridge_assertions_inst (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.rx_valid  (rx_valid),
		.wr_en     (wr_en),
		.clr_cnt   (clr_cnt)
	);

	initial begin
		sys_clk = 1'b0;
		forever #5 sys_clk = ~sys_clk;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("timeout: tests still running after %0d sys_clk cycles", timeout_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

	function automatic int rand_range(input int lo, input int hi);
		int r;
		r = $random(seed) & 32'h7fff_ffff;
		return lo + r % (hi - lo + 1);
	endfunction

	// command byte through the view that matches the kind
	function automatic logic [7:0] cmd_byte(input spi_link_pkg::cmd_kind_e kind,
		input logic [5:0] low);
		spi_link_pkg::cmd_word_u cw;
		if (kind == spi_link_pkg::cmd_sys) begin
			cw.sys_cmd.kind   = kind;
			cw.sys_cmd.opcode = low;
		end else begin
			cw.reg_cmd.kind = kind;
			cw.reg_cmd.addr = low;
		end
		return cw;
	endfunction

	function automatic logic [7:0] model_value(input logic [2:0] a);
		if (a == reg_map_pkg::reg_frame_cnt)
			return exp_cnt;
		else if (a == reg_map_pkg::reg_id)
			return exp_id;
		else
			return model_reg[a];                       // rw regs and in_port
	endfunction

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		check_count++;
		assert (act == exp) else begin
			$display("ERR %s expected %02h actual %02h", name, exp, act);
			err_count++;
		end
	endtask

	task automatic start_test();
		test_checks = check_count;
		test_errs   = err_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %-10s %0d checks, %0d errors", name,
			check_count - test_checks, err_count - test_errs);
	endtask

	// cs low, n bytes msb first, cs high, then the gap
	task automatic play_frame(input int n);
		cs = 1'b0;
		repeat (half_period) @(negedge sys_clk);
		for (int k = 0; k < n; k++) begin
			for (int i = 7; i >= 0; i--) begin
				sclk = 1'b0;                           // launch edge
				mosi = mosi_buf[k][i];
				repeat (half_period) @(negedge sys_clk);
				miso_buf[k][i] = miso;                 // settled since launch
				sclk = 1'b1;                           // sample edge
				repeat (half_period) @(negedge sys_clk);
			end
		end
		repeat (half_period) @(negedge sys_clk);
		cs = 1'b1;
		repeat (frame_gap) @(negedge sys_clk);
	endtask

	// one frame, replies checked against the model, then the model moves on
	task automatic transfer(input string name, input logic [7:0] cmd, input int n_data);
		spi_link_pkg::cmd_word_u cw;
		logic [7:0]              exp_rd [0:15];
		logic [2:0]              a;
		cw = cmd;
		a  = cw.reg_cmd.addr[2:0];                     // upper address bits wrap
		for (int k = 1; k <= n_data; k++) begin
			exp_rd[k] = model_value(a);
			a = a + 3'd1;
		end
		mosi_buf[0] = cmd;
		play_frame(n_data + 1);
		check_byte({name, "_cmd"}, reg_map_pkg::status_byte, miso_buf[0]);
		a = cw.reg_cmd.addr[2:0];
		for (int k = 1; k <= n_data; k++) begin
			if (cw.reg_cmd.kind == spi_link_pkg::cmd_read)
				check_byte(name, exp_rd[k], miso_buf[k]);
			else if (cw.reg_cmd.kind == spi_link_pkg::cmd_write && a <= reg_map_pkg::reg_gp_hi)
				model_reg[a] = mosi_buf[k];            // read-only targets keep their value
			a = a + 3'd1;
		end
		if (cw.sys_cmd.kind == spi_link_pkg::cmd_sys &&
		    cw.sys_cmd.opcode == reg_map_pkg::sys_op_clr_cnt)
			exp_cnt = 8'h00;
		exp_cnt = exp_cnt + 8'd1;                      // clear frame counts itself
	endtask

	initial begin
		int         len;
		logic [5:0] addr;
		seed        = 99614;
		check_count = 0;
		err_count   = 0;
		test_count  = 0;
		cs          = 1'b1;
		sclk        = 1'b1;                            // cpol 1 idle
		mosi        = 1'b1;
		in_port     = 8'h3C;
		sys_rst_n   = 1'b0;
		for (int i = 0; i < 8; i++)
			model_reg[i] = 8'h00;
		model_reg[reg_map_pkg::reg_in_port] = 8'h3C;
		exp_cnt = 8'h00;
		exp_id  = 8'hA5;
		repeat (16) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		repeat (4) @(negedge sys_clk);

		start_test();
		check_byte("reset_out", 8'h00, out_port);
		transfer("id_read", cmd_byte(spi_link_pkg::cmd_read, 6'd7), 1);
		end_test("reset_id");

		start_test();
		repeat (8) begin
			addr = 6'(rand_range(0, 63));
			len  = rand_range(1, 4);
			for (int k = 1; k <= len; k++)
				mosi_buf[k] = 8'(rand_range(0, 255));
			transfer("burst_wr", cmd_byte(spi_link_pkg::cmd_write, addr), len);
			transfer("burst_rd", cmd_byte(spi_link_pkg::cmd_read, addr), len);
		end
		end_test("bursts");

		start_test();
		repeat (4) begin
			mosi_buf[1] = 8'(rand_range(0, 255));
			transfer("out_wr", cmd_byte(spi_link_pkg::cmd_write, 6'd0), 1);
			check_byte("out_port", model_reg[reg_map_pkg::reg_out_a], out_port);
		end
		end_test("out_port");

		start_test();
		repeat (4) begin
			in_port = 8'(rand_range(0, 255));          // held through the frame
			model_reg[reg_map_pkg::reg_in_port] = in_port;
			transfer("in_rd", cmd_byte(spi_link_pkg::cmd_read, 6'd5), 1);
		end
		end_test("in_port");

		start_test();
		transfer("clr", cmd_byte(spi_link_pkg::cmd_sys, 6'd1), 0);
		transfer("cnt_rd", cmd_byte(spi_link_pkg::cmd_read, 6'd6), 1);
		while (exp_cnt != 8'hFF)
			transfer("cnt_pad", cmd_byte(spi_link_pkg::cmd_read, 6'd0), 0);
		transfer("cnt_top", cmd_byte(spi_link_pkg::cmd_read, 6'd6), 1);
		transfer("cnt_wrap", cmd_byte(spi_link_pkg::cmd_read, 6'd6), 1);
		transfer("clr", cmd_byte(spi_link_pkg::cmd_sys, 6'd1), 0);
		transfer("cnt_clr", cmd_byte(spi_link_pkg::cmd_read, 6'd6), 1);
		end_test("frame_cnt");

		start_test();
		for (int k = 1; k <= 3; k++)
			mosi_buf[k] = 8'(rand_range(0, 255));
		transfer("rsvd", cmd_byte(spi_link_pkg::cmd_rsvd, 6'(rand_range(0, 63))), 3);
		transfer("bad_sys", cmd_byte(spi_link_pkg::cmd_sys, 6'(rand_range(2, 63))), 3);
		transfer("readback", cmd_byte(spi_link_pkg::cmd_read, 6'd0), 8);
		end_test("ignored");

		$display("summary: %0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
		if (err_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

// File: spi_regbridge.f
source/spi_link_pkg.sv
source/reg_map_pkg.sv
source/spi_slave.sv
source/spi_cmd_ctrl.sv
source/spi_reg_file.sv
source/spi_regbridge_top.sv
test/spi_regbridge_assertions.sv
test/tb_spi_regbridge.sv

// File: run_sim.sh
#!/bin/sh
# builds the spi_regbridge testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_spi_regbridge -f spi_regbridge.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_spi_regbridge)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_out" | grep -qx "NO ERRORS"; then
	exit 0
fi
exit 1
